// File: include/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'hbfc00000

// general exception entry
`define FETCH_EXC_VECTOR 32'hbfc00380

// bus width is one line of two instructions
`define FETCH_LINE_BYTES 8
`define FETCH_ADDR_WIDTH 32

`endif

// File: source/fetch_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_WIDTH-1:0] word_t;

    // redirect from commit, flags in priority order
    typedef struct packed {
        logic  exception_valid;
        logic  is_eret;
        logic  branch;
        logic  jump;
        logic  jr;
        word_t epc;
        word_t pc_branch;
        word_t pc_jump;
        word_t pc_jr;
    } redirect_t;

    // one instruction handed to decode
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_slot_t;

endpackage

`default_nettype wire

// File: source/fetch_pipe_if.sv
`default_nettype none

interface fetch_pipe_if;
    import fetch_pkg::*;

    // request accepted by the bus this cycle
    logic  issued;
    // fetch address of that request, bit 2 still set when unaligned
    word_t pc;
    // transaction in flight, issued until data_ok
    logic  busy;
    // bundle left, or a stale response was thrown away
    logic  done;

    modport issue (
        output issued,
        output pc,
        input  busy,
        input  done
    );

    modport collect (
        input  issued,
        input  pc,
        output busy,
        output done
    );

endinterface

`default_nettype wire

// File: source/redirect_select.sv
`default_nettype none

`include "fetch_cfg.svh"

module redirect_select (
    input  logic                clk,
    input  logic                reset,
    input  fetch_pkg::redirect_t redirect,
    input  logic                redirect_strobe,
    input  logic                busy,
    output fetch_pkg::word_t    target,
    output logic                take,
    output logic                pending
);
    import fetch_pkg::*;

    word_t sel_target;
    word_t hold_target;
    logic  hold_valid;
    logic  any_kind;

    assign any_kind = redirect.exception_valid | redirect.is_eret | redirect.branch |
                      redirect.jump | redirect.jr;

    // fixed priority, exception wins
    always_comb
    begin
        if (redirect.exception_valid)
            sel_target = `FETCH_EXC_VECTOR;
        else if (redirect.is_eret)
            sel_target = redirect.epc;
        else if (redirect.branch)
            sel_target = redirect.pc_branch;
        else if (redirect.jump)
            sel_target = redirect.pc_jump;
        else
            sel_target = redirect.pc_jr;
    end

    always_ff @(posedge clk)
    begin
        if (~reset)
            hold_valid <= 1'b0;
        else if (redirect_strobe & any_kind)
            hold_valid <= 1'b1;
        else if (take)
            hold_valid <= 1'b0;
    end

    // a newer strobe simply overwrites the held target
    always_ff @(posedge clk)
    begin
        if (redirect_strobe & any_kind)
            hold_target <= sel_target;
    end

    // released only once the bus has gone quiet
    assign take    = hold_valid & ~busy;
    assign target  = hold_target;
    // anything still waiting, including this cycle's strobe
    assign pending = (hold_valid & busy) | (redirect_strobe & any_kind);

endmodule

`default_nettype wire

// File: source/pc_stage.sv
`default_nettype none

`include "fetch_cfg.svh"

module pc_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             take,
    input  fetch_pkg::word_t target,
    input  logic             stall,
    fetch_pipe_if.issue      pipe,
    output logic             imem_req,
    output fetch_pkg::word_t imem_addr,
    input  logic             imem_addr_ok
);
    import fetch_pkg::*;

    word_t pc;
    word_t fetch_addr;
    word_t line_addr;
    word_t next_pc;
    logic  outstanding;

    // a redirect released this cycle goes straight onto the bus
    assign fetch_addr = take ? target : pc;

    // bus address is always line aligned
    assign line_addr = {fetch_addr[`FETCH_ADDR_WIDTH-1:3], 3'b000};

    // pc+8 when aligned, pc+4 from the upper half; both land on the next line
    assign next_pc = line_addr + word_t'(`FETCH_LINE_BYTES);

    // one request until its bundle is gone, frozen under stall
    assign imem_req  = (~outstanding | pipe.done) & ~stall;
    assign imem_addr = line_addr;

    assign pipe.issued = imem_req & imem_addr_ok;
    assign pipe.pc     = fetch_addr;

    always_ff @(posedge clk)
    begin
        if (~reset)
        begin
            outstanding <= 1'b0;
        end
        else if (pipe.issued)
        begin
            outstanding <= 1'b1;
        end
        else if (pipe.done)
        begin
            outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (~reset)
        begin
            pc <= `FETCH_RESET_PC;
        end
        else if (pipe.issued)
        begin
            // fetch_addr already includes a redirect taken this cycle
            pc <= next_pc;
        end
        else if (take)
        begin
            pc <= target;
        end
    end

endmodule

`default_nettype wire

// File: source/instr_stage.sv
`default_nettype none

`include "fetch_cfg.svh"

module instr_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pending,
    input  logic                        take,
    input  logic                        stall,
    fetch_pipe_if.collect               pipe,
    input  logic                        imem_data_ok,
    input  logic [`FETCH_LINE_BYTES*8-1:0] imem_data,
    output logic                        fetch_valid,
    output fetch_pkg::fetch_slot_t [1:0] fetch_slots,
    output logic [1:0]                  hit
);
    import fetch_pkg::*;

    logic  busy_q;
    logic  stale;
    logic  drop;
    logic  drop_q;
    logic  valid_q;
    word_t req_pc;

    // redirected transaction, or a redirect meeting its data_ok
    assign drop = stale | pending;

    always_ff @(posedge clk)
    begin
        if (~reset)
        begin
            busy_q  <= 1'b0;
            stale   <= 1'b0;
            drop_q  <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            drop_q <= imem_data_ok & drop;

            if (pipe.issued)
                busy_q <= 1'b1;
            else if (imem_data_ok)
                busy_q <= 1'b0;

            if (imem_data_ok)
                stale <= 1'b0;
            else if (pending & (busy_q | pipe.issued))
                stale <= 1'b1;

            // held while decode stalls, killed by a redirect
            if (imem_data_ok & ~drop)
                valid_q <= 1'b1;
            else if (~stall | take)
                valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipe.issued)
            req_pc <= pipe.pc;
    end

    // low word sits at the line address, high word at +4
    always_ff @(posedge clk)
    begin
        if (imem_data_ok & ~drop)
        begin
            if (req_pc[2])
            begin
                hit                  <= 2'b01;
                fetch_slots[0].pc    <= req_pc;
                fetch_slots[0].instr <= imem_data[63:32];
                fetch_slots[1]       <= '0;
            end
            else
            begin
                hit                  <= 2'b11;
                fetch_slots[0].pc    <= req_pc;
                fetch_slots[0].instr <= imem_data[31:0];
                fetch_slots[1].pc    <= req_pc + word_t'(4);
                fetch_slots[1].instr <= imem_data[63:32];
            end
        end
    end

    assign fetch_valid = valid_q;
    assign pipe.busy   = busy_q;
    assign pipe.done   = (valid_q & (~stall | take)) | drop_q;

endmodule

`default_nettype wire

// File: source/quick_fetch.sv
`default_nettype none

`include "fetch_cfg.svh"

module quick_fetch (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,
    input  logic                           exception_valid,
    input  logic                           is_eret,
    input  logic                           branch,
    input  logic                           jump,
    input  logic                           jr,
    input  fetch_pkg::word_t               epc,
    input  fetch_pkg::word_t               pc_branch,
    input  fetch_pkg::word_t               pc_jump,
    input  fetch_pkg::word_t               pc_jr,
    input  logic                           redirect_strobe,
    output logic                           imem_req,
    output fetch_pkg::word_t               imem_addr,
    input  logic                           imem_addr_ok,
    input  logic                           imem_data_ok,
    input  logic [`FETCH_LINE_BYTES*8-1:0] imem_data,
    output logic                           fetch_valid,
    output fetch_pkg::word_t               fetch_pc0,
    output fetch_pkg::word_t               fetch_instr0,
    output fetch_pkg::word_t               fetch_pc1,
    output fetch_pkg::word_t               fetch_instr1,
    output logic [1:0]                     hit
);
    import fetch_pkg::*;

    redirect_t         commit_redirect;
    word_t             redirect_target;
    logic              take;
    logic              pending;
    fetch_slot_t [1:0] slots;

    fetch_pipe_if pipe ();

    assign commit_redirect.exception_valid = exception_valid;
    assign commit_redirect.is_eret         = is_eret;
    assign commit_redirect.branch          = branch;
    assign commit_redirect.jump            = jump;
    assign commit_redirect.jr              = jr;
    assign commit_redirect.epc             = epc;
    assign commit_redirect.pc_branch       = pc_branch;
    assign commit_redirect.pc_jump         = pc_jump;
    assign commit_redirect.pc_jr           = pc_jr;

    redirect_select u_redirect_select (
        .clk             (clk),
        .reset           (reset),
        .redirect        (commit_redirect),
        .redirect_strobe (redirect_strobe),
        .busy            (pipe.busy),
        .target          (redirect_target),
        .take            (take),
        .pending         (pending)
    );

    pc_stage u_pc_stage (
        .clk          (clk),
        .reset        (reset),
        .take         (take),
        .target       (redirect_target),
        .stall        (stall),
        .pipe         (pipe.issue),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_addr_ok (imem_addr_ok)
    );

    instr_stage u_instr_stage (
        .clk          (clk),
        .reset        (reset),
        .pending      (pending),
        .take         (take),
        .stall        (stall),
        .pipe         (pipe.collect),
        .imem_data_ok (imem_data_ok),
        .imem_data    (imem_data),
        .fetch_valid  (fetch_valid),
        .fetch_slots  (slots),
        .hit          (hit)
    );

    assign fetch_pc0    = slots[0].pc;
    assign fetch_instr0 = slots[0].instr;
    assign fetch_pc1    = slots[1].pc;
    assign fetch_instr1 = slots[1].instr;

endmodule

`default_nettype wire

// File: test/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // active low, released just after the tenth edge
    initial
    begin
        reset = 1'b0;
        repeat (10) @(posedge clk);
        #1 reset = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/fetch_checker.sv
`default_nettype none

`include "fetch_cfg.svh"

module fetch_checker (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic             imem_req,
    input  fetch_pkg::word_t imem_addr,
    input  logic             imem_addr_ok,
    input  logic             imem_data_ok,
    input  logic             fetch_valid,
    input  fetch_pkg::word_t fetch_pc0,
    input  fetch_pkg::word_t fetch_instr0,
    input  fetch_pkg::word_t fetch_pc1,
    input  fetch_pkg::word_t fetch_instr1,
    input  logic [1:0]       hit,
    output logic             all_done,
    output int               errors
);
    import fetch_pkg::*;

    // memory model returns address xor this key
    localparam word_t INSTR_KEY = 32'h5a5a0000;

    string  names[16];
    int     test_end[16];
    word_t  exp_pc[256];
    int     num_tests;
    int     total;
    int     idx;
    int     t;
    int     checks;
    int     test_err;
    int     passed;
    int     failed;
    logic   started;
    logic   bus_busy;
    logic   held;
    logic [129:0] snapshot;

    task automatic load_expected();
        int    fd;
        int    r;
        int    n;
        int    k;
        string tok;
        string line;
        fd = $fopen("test/fetch_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open test/fetch_trace.txt");
            errors++;
        end
        else
        begin
            while ($fscanf(fd, "%s", tok) == 1)
            begin
                if (tok == "T")
                begin
                    r = $fscanf(fd, "%s %d", names[num_tests], n);
                    test_end[num_tests] = total;
                    num_tests++;
                end
                else if (tok == "E")
                begin
                    r = $fscanf(fd, "%d", n);
                    for (k = 0; k < n; k++)
                    begin
                        r = $fscanf(fd, "%h", exp_pc[total]);
                        total++;
                    end
                    test_end[num_tests-1] = total;
                end
                else
                    r = $fgets(line, fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic flag(input string what, input word_t want, input word_t got);
        $display("Fail %s: %s expected %h actual %h", names[t], what, want, got);
        errors++;
        test_err++;
    endtask

    task automatic report(input string what);
        $display("%s", what);
        errors++;
        test_err++;
    endtask

    // one transaction at a time and no request over a held bundle
    task automatic check_bus();
        if (!started)
        begin
            started = 1'b1;
            if (imem_req !== 1'b1)
                report("no fetch request in the first cycle after reset");
            else if (imem_addr !== `FETCH_RESET_PC)
                flag("first request", `FETCH_RESET_PC, imem_addr);
        end
        if (imem_req && bus_busy)
            report("fetch request raised while a transaction was in flight");
        if (imem_req && fetch_valid && stall)
            report("fetch request raised while a stalled bundle was held");
        if (imem_data_ok)
            bus_busy = 1'b0;
        if (imem_req && imem_addr_ok)
            bus_busy = 1'b1;
    endtask

    task automatic check_slot(input word_t pc, input word_t instr);
        word_t want;
        want = exp_pc[idx];
        checks += 2;
        if (pc !== want)
            flag("slot pc", want, pc);
        if (instr !== (want ^ INSTR_KEY))
            flag("slot instr", want ^ INSTR_KEY, instr);
        idx++;
    endtask

    task automatic check_bundle();
        logic [1:0] want_hit;
        if (idx >= total)
        begin
            report($sformatf("a bundle at pc %h arrived after the last expected one",
                             fetch_pc0));
        end
        else
        begin
            // unaligned pc only fills slot 0
            want_hit = exp_pc[idx][2] ? 2'b01 : 2'b11;
            checks++;
            if (hit !== want_hit)
                flag("hit", word_t'(want_hit), word_t'(hit));
            check_slot(fetch_pc0, fetch_instr0);
            if (want_hit[1])
                check_slot(fetch_pc1, fetch_instr1);
            if (idx >= test_end[t])
            begin
                if (test_err == 0)
                    passed++;
                else
                    failed++;
                $display("test %s: %s (%0d errors)", names[t],
                         test_err == 0 ? "ok" : "failed", test_err);
                test_err = 0;
                t++;
            end
        end
    endtask

    initial
    begin
        errors = 0;
        num_tests = 0;
        total = 0;
        idx = 0;
        t = 0;
        checks = 0;
        test_err = 0;
        passed = 0;
        failed = 0;
        started = 1'b0;
        bus_busy = 1'b0;
        held = 1'b0;
        all_done = 1'b0;
        snapshot = '0;
        load_expected();
    end

    // outputs and stall are both settled at the falling edge
    always @(negedge clk)
    begin
        if (reset && !all_done)
        begin
            check_bus();
            if (held && !fetch_valid)
                report("fetch_valid dropped while a bundle was held by stall");
            if (fetch_valid && stall)
            begin
                if (held && snapshot !== {hit, fetch_pc0, fetch_instr0, fetch_pc1, fetch_instr1})
                    report("held bundle changed while stall was high");
                snapshot = {hit, fetch_pc0, fetch_instr0, fetch_pc1, fetch_instr1};
                held = 1'b1;
            end
            else
            begin
                held = 1'b0;
                if (fetch_valid)
                    check_bundle();
            end
            if (t >= num_tests)
            begin
                $display("tests passed %0d failed %0d, checks %0d, errors %0d",
                         passed, failed, checks, errors);
                all_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/fetch_tb.sv
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam word_t INSTR_KEY = 32'h5a5a0000;

    logic       clk;
    logic       reset;
    logic       stall;
    logic       exception_valid;
    logic       is_eret;
    logic       branch;
    logic       jump;
    logic       jr;
    word_t      epc;
    word_t      pc_branch;
    word_t      pc_jump;
    word_t      pc_jr;
    logic       redirect_strobe;
    logic       imem_req;
    word_t      imem_addr;
    logic       imem_addr_ok;
    logic       imem_data_ok;
    logic [`FETCH_LINE_BYTES*8-1:0] imem_data;
    logic       fetch_valid;
    word_t      fetch_pc0;
    word_t      fetch_instr0;
    word_t      fetch_pc1;
    word_t      fetch_instr1;
    logic [1:0] hit;
    logic       all_done;
    int         errors;

    // redirect and stall events, bundle numbers counted over the whole run
    int         num_tests;
    int         num_ev;
    int         num_st;
    int         total_bundles;
    int         ev_bundle[32];
    int         ev_offset[32];
    logic [4:0] ev_kinds[32];
    word_t      ev_epc[32];
    word_t      ev_branch[32];
    word_t      ev_jump[32];
    word_t      ev_jr[32];
    int         st_bundle[32];
    int         st_len[32];

    // bus model state
    int         seed;
    int         addr_wait;
    int         data_wait;
    logic       in_flight;
    word_t      line_addr;

    int         bundles;
    logic       held;
    int         stall_left;
    int         fire_ev;
    int         fire_wait;

    clock_gen clock0 (.*);
    quick_fetch dut0 (.*);
    fetch_checker checker0 (.*);

    task automatic load_stimulus();
        int    fd;
        int    r;
        int    n;
        int    base;
        string tok;
        string name;
        string line;
        base = 0;
        fd = $fopen("test/fetch_trace.txt", "r");
        if (fd != 0)
        begin
            while ($fscanf(fd, "%s", tok) == 1)
            begin
                if (tok == "T")
                begin
                    r = $fscanf(fd, "%s %d", name, n);
                    base = total_bundles;
                    total_bundles += n;
                    num_tests++;
                end
                else if (tok == "R")
                begin
                    r = $fscanf(fd, "%d %d %b %h %h %h %h", ev_bundle[num_ev],
                                ev_offset[num_ev], ev_kinds[num_ev], ev_epc[num_ev],
                                ev_branch[num_ev], ev_jump[num_ev], ev_jr[num_ev]);
                    ev_bundle[num_ev] += base;
                    num_ev++;
                end
                else if (tok == "S")
                begin
                    r = $fscanf(fd, "%d %d", st_bundle[num_st], st_len[num_st]);
                    st_bundle[num_st] += base;
                    num_st++;
                end
                else
                    r = $fgets(line, fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_redirect(input int i);
        {exception_valid, is_eret, branch, jump, jr} = ev_kinds[i];
        epc = ev_epc[i];
        pc_branch = ev_branch[i];
        pc_jump = ev_jump[i];
        pc_jr = ev_jr[i];
        redirect_strobe = 1'b1;
    endtask

    // stall and redirects keyed to the delivered bundle count
    task automatic drive_cycle();
        logic fresh;
        int   i;
        fresh = fetch_valid & ~held;
        redirect_strobe = 1'b0;
        {exception_valid, is_eret, branch, jump, jr} = 5'b0;
        if (fresh)
            bundles++;
        stall = 1'b0;
        if (stall_left > 0)
        begin
            stall = 1'b1;
            stall_left--;
        end
        else if (fresh)
        begin
            for (i = 0; i < num_st; i++)
            begin
                if (st_bundle[i] == bundles)
                begin
                    stall = 1'b1;
                    stall_left = st_len[i] - 1;
                end
            end
        end
        if (fire_wait == 0)
            apply_redirect(fire_ev);
        if (fire_wait >= 0)
            fire_wait--;
        if (fresh)
        begin
            for (i = 0; i < num_ev; i++)
            begin
                if (ev_bundle[i] == bundles && ev_offset[i] == 0)
                    apply_redirect(i);
                else if (ev_bundle[i] == bundles)
                begin
                    fire_ev = i;
                    fire_wait = ev_offset[i] - 1;
                end
            end
        end
        held = fetch_valid & stall;
    endtask

    // one request at a time, random accept and response delays
    task automatic step_memory();
        imem_addr_ok = 1'b0;
        imem_data_ok = 1'b0;
        if (in_flight)
        begin
            data_wait--;
            if (data_wait == 0)
            begin
                imem_data_ok = 1'b1;
                imem_data = {(line_addr + 32'd4) ^ INSTR_KEY, line_addr ^ INSTR_KEY};
                in_flight = 1'b0;
            end
        end
        else if (imem_req)
        begin
            if (addr_wait < 0)
                addr_wait = $unsigned($random(seed)) % 4;
            if (addr_wait == 0)
            begin
                imem_addr_ok = 1'b1;
                line_addr = imem_addr;
                in_flight = 1'b1;
                data_wait = 1 + $unsigned($random(seed)) % 4;
                addr_wait = -1;
            end
            else
                addr_wait--;
        end
    endtask

    initial
    begin
        stall = 1'b0;
        redirect_strobe = 1'b0;
        {exception_valid, is_eret, branch, jump, jr} = 5'b0;
        epc = '0;
        pc_branch = '0;
        pc_jump = '0;
        pc_jr = '0;
        imem_addr_ok = 1'b0;
        imem_data_ok = 1'b0;
        imem_data = '0;
        seed = 64;
        addr_wait = -1;
        data_wait = 0;
        in_flight = 1'b0;
        line_addr = '0;
        bundles = 0;
        held = 1'b0;
        stall_left = 0;
        fire_ev = 0;
        fire_wait = -1;
        num_tests = 0;
        num_ev = 0;
        num_st = 0;
        total_bundles = 0;
        load_stimulus();
        wait (reset === 1'b1);
        while (!all_done)
        begin
            @(posedge clk);
            #1;
            drive_cycle();
            #1;
            step_memory();
        end
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog
    initial
    begin
        #1;
        repeat (200 * num_tests + 100) @(posedge clk);
        $display("run timed out after %0d cycles", 200 * num_tests + 100);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
source/fetch_pkg.sv
source/fetch_pipe_if.sv
source/redirect_select.sv
source/pc_stage.sv
source/instr_stage.sv
source/quick_fetch.sv
test/clock_gen.sv
test/fetch_checker.sv
test/fetch_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run from the project root, then scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module fetch_tb -f project.f -o fetch_sim > build.log 2>&1 &&
./obj_dir/fetch_sim > sim.log 2>&1 ||
{ cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
exit 0

// File: test/fetch_trace.txt
# T name bundles | R bundle offset kinds(exc eret br j jr) epc pc_branch pc_jump pc_jr
# S bundle cycles | E count then expected slot pcs in delivery order
T reset_sequence 4
E 8 bfc00000 bfc00004 bfc00008 bfc0000c bfc00010 bfc00014 bfc00018 bfc0001c
T unaligned_target 3
R 0 0 00010 00000000 00000000 80001004 00000000
E 5 80001004 80001008 8000100c 80001010 80001014
T redirect_priority 5
R 0 0 11111 80009990 80009998 800099a0 800099a8
R 1 0 01111 80002000 80009998 800099a0 800099a8
R 2 0 00111 00000000 80003000 800099a0 800099a8
R 3 0 00011 00000000 00000000 80004008 800099a8
R 4 0 00001 00000000 00000000 00000000 8000500c
E 9 bfc00380 bfc00384 80002000 80002004 80003000 80003004 80004008 8000400c 8000500c
T stale_redirect 3
R 0 1 00100 00000000 80006000 00000000 00000000
R 2 1 00001 00000000 00000000 00000000 80007000
E 6 80006000 80006004 80006008 8000600c 80007000 80007004
T stall_hold 4
R 0 0 00010 00000000 00000000 80008000 00000000
S 1 5
S 3 2
E 8 80008000 80008004 80008008 8000800c 80008010 80008014 80008018 8000801c
T mixed_long 11
R 0 0 00001 00000000 00000000 00000000 80010004
R 3 1 00100 00000000 80020000 00000000 00000000
S 4 3
R 5 0 01000 8002100c 00000000 00000000 00000000
S 7 2
R 8 1 10000 00000000 00000000 00000000 00000000
E 8 80010004 80010008 8001000c 80010010 80010014 80020000 80020004 80020008
E 8 8002000c 8002100c 80021010 80021014 80021018 8002101c bfc00380 bfc00384
E 4 bfc00388 bfc0038c bfc00390 bfc00394
